// File: Bender.yml
package:
  name: msx_frame

sources:
  - hdl/msx_frame_pkg.sv
  - hdl/frame_if.sv
  - hdl/status_decode.sv
  - hdl/sd_route.sv
  - hdl/cassette_control.sv
  - hdl/video_format.sv
  - hdl/msx_frame.sv
  - target: simulation
    files:
      - tb/tb_clock.sv
      - tb/tb_msx_frame.sv

// File: hdl/cassette_control.sv
module cassette_control (
   input  logic                     clock_bus,
   input  logic                     rst,
   settings_if.tape_mp              settings,
   input  logic                     dl_active,
   input  msx_frame_pkg::dl_index_t dl_index,
   input  logic                     motor_on,

   input  logic                     dl_request,
   input  msx_frame_pkg::ddr_addr_t dl_addr,
   input  logic                     dl_rd,
   input  msx_frame_pkg::ddr_addr_t tape_addr,
   input  logic                     tape_rd,

   output msx_frame_pkg::ddr_addr_t ddr_addr,
   output logic                     ddr_rd,
   output logic                     cas_load,
   output logic                     tape_play,
   output logic                     tape_rewind_out
);

   logic cas_active;
   logic cas_active_last;
   logic cas_end;

   // ====================
   // CAS load detection
   // ====================

   assign cas_active = dl_active &
      (dl_index[msx_frame_pkg::DL_MATCH_W-1:0] ==
       msx_frame_pkg::DL_MATCH_W'(msx_frame_pkg::DL_INDEX_CAS));

   // Falling edge of a cassette download
   assign cas_end = cas_active_last & ~cas_active;

   always_ff @(posedge clock_bus) begin
      if (rst) begin
         cas_active_last <= 1'b0;
         cas_load        <= 1'b0;
      end else begin
         cas_active_last <= cas_active;
         // Sticky until the next reset
         if (cas_end) begin
            cas_load <= 1'b1;
         end
      end
   end

   // ====================
   // Player controls
   // ====================

   // Motor line from the PPI is active low for the player
   assign tape_play = ~motor_on & cas_load;

   // Rewind to the start while a new file is coming in
   assign tape_rewind_out = settings.tape_rewind | cas_active;

   // ====================
   // DDR3 read port
   // ====================

   // Download owns the buffer whenever it asks
   always_comb begin
      if (dl_request) begin
         ddr_addr = dl_addr;
         ddr_rd   = dl_rd;
      end else begin
         ddr_addr = tape_addr;
         ddr_rd   = tape_rd;
      end
   end

   a_no_tape_read : assert property (
      @(posedge clock_bus) disable iff (rst)
      (dl_request && tape_rd && !dl_rd) |-> !ddr_rd
   ) else $error("tape read reached DDR3 during a download");

endmodule

// File: hdl/frame_if.sv
// Decoded platform settings, shared by decode, video and tape logic
interface settings_if;

   msx_frame_pkg::aspect_t aspect;
   msx_frame_pkg::scale_t  scale;
   logic                   scandoubler;
   logic                   tape_rewind;

   // Written by the status decoder
   modport decode_mp (
      output aspect,
      output scale,
      output scandoubler,
      output tape_rewind
   );

   // Scaler and LED side
   modport result_mp (
      input aspect,
      input scale,
      input scandoubler
   );

   // Cassette player side
   modport tape_mp (
      input tape_rewind
   );

endinterface

// File: hdl/msx_frame.sv
module msx_frame (
   input  logic                                  clock_bus,
   input  logic                                  rst,

   // Platform status and resets
   input  msx_frame_pkg::status_t                status,
   input  logic                                  upload_reset,
   input  logic                                  forced_scandoubler,
   output logic                                  hard_reset,
   output logic                                  core_reset,
   output logic                                  sram_save,
   output logic                                  sram_load,
   output logic                                  tape_adc_src,

   // SD card and virtual image
   input  logic                                  img_mounted,
   input  logic [msx_frame_pkg::IMG_SIZE_W-1:0]  img_size,
   input  logic                                  spi_clk,
   input  logic                                  spi_mosi,
   input  logic                                  vsd_miso,
   input  logic                                  sd_miso,
   output logic                                  spi_miso,
   output logic                                  sd_cs,
   output logic                                  sd_sck,
   output logic                                  sd_mosi,

   // Cassette and DDR3 buffer
   input  logic                                  dl_active,
   input  msx_frame_pkg::dl_index_t              dl_index,
   input  logic                                  motor_on,
   input  logic                                  dl_request,
   input  msx_frame_pkg::ddr_addr_t              dl_addr,
   input  logic                                  dl_rd,
   input  msx_frame_pkg::ddr_addr_t              tape_addr,
   input  logic                                  tape_rd,
   output msx_frame_pkg::ddr_addr_t              ddr_addr,
   output logic                                  ddr_rd,
   output logic                                  cas_load,
   output logic                                  tape_play,
   output logic                                  tape_rewind_out,

   // Scaler and LEDs
   input  logic [msx_frame_pkg::HDMI_DIM_W-1:0]  hdmi_width,
   input  logic [msx_frame_pkg::HDMI_DIM_W-1:0]  hdmi_height,
   output msx_frame_pkg::ratio_t                 video_arx,
   output msx_frame_pkg::ratio_t                 video_ary,
   output logic [1:0]                            vga_sl,
   output msx_frame_pkg::ratio_t                 crop_size,
   output logic                                  hq2x,
   output logic                                  led_user,
   output logic [1:0]                            led_disk
);

   logic vsd_sel;
   logic sd_act;

   settings_if settings ();

   status_decode u_status_decode (
      .clock_bus          (clock_bus),
      .rst                (rst),
      .status             (status),
      .upload_reset       (upload_reset),
      .forced_scandoubler (forced_scandoubler),
      .settings           (settings.decode_mp),
      .hard_reset         (hard_reset),
      .core_reset         (core_reset),
      .sram_save          (sram_save),
      .sram_load          (sram_load),
      .tape_adc_src       (tape_adc_src)
   );

   sd_route u_sd_route (
      .clock_bus   (clock_bus),
      .rst         (rst),
      .img_mounted (img_mounted),
      .img_size    (img_size),
      .spi_clk     (spi_clk),
      .spi_mosi    (spi_mosi),
      .vsd_miso    (vsd_miso),
      .sd_miso     (sd_miso),
      .spi_miso    (spi_miso),
      .sd_cs       (sd_cs),
      .sd_sck      (sd_sck),
      .sd_mosi     (sd_mosi),
      .vsd_sel     (vsd_sel),
      .sd_act      (sd_act)
   );

   cassette_control u_cassette_control (
      .clock_bus       (clock_bus),
      .rst             (rst),
      .settings        (settings.tape_mp),
      .dl_active       (dl_active),
      .dl_index        (dl_index),
      .motor_on        (motor_on),
      .dl_request      (dl_request),
      .dl_addr         (dl_addr),
      .dl_rd           (dl_rd),
      .tape_addr       (tape_addr),
      .tape_rd         (tape_rd),
      .ddr_addr        (ddr_addr),
      .ddr_rd          (ddr_rd),
      .cas_load        (cas_load),
      .tape_play       (tape_play),
      .tape_rewind_out (tape_rewind_out)
   );

   video_format u_video_format (
      .clock_bus   (clock_bus),
      .rst         (rst),
      .settings    (settings.result_mp),
      .hdmi_width  (hdmi_width),
      .hdmi_height (hdmi_height),
      .vsd_sel     (vsd_sel),
      .sd_act      (sd_act),
      .video_arx   (video_arx),
      .video_ary   (video_ary),
      .vga_sl      (vga_sl),
      .crop_size   (crop_size),
      .hq2x        (hq2x),
      .led_user    (led_user),
      .led_disk    (led_disk)
   );

endmodule

// File: hdl/msx_frame_pkg.sv
package msx_frame_pkg;

   // ====================
   // Platform status word
   // ====================

   localparam int status_w = 64;

   typedef logic [status_w-1:0] status_t;

   // Bit positions inside the status word
   localparam int ST_RESET       = 0;
   localparam int ST_ASPECT_LO   = 1;
   localparam int ST_SCALE_LO    = 3;
   localparam int ST_TAPE_REWIND = 9;
   localparam int ST_SLOT_DETACH = 10;
   localparam int ST_SRAM_SAVE   = 38;
   localparam int ST_SRAM_LOAD   = 39;
   localparam int ST_TAPE_SRC    = 40;

   // Field widths
   localparam int ASPECT_W   = 2;
   localparam int SCALE_W    = 3;
   localparam int RATIO_W    = 12;
   localparam int HDMI_DIM_W = 12;
   localparam int IMG_SIZE_W = 64;
   localparam int DDR_ADDR_W = 28;
   localparam int DL_INDEX_W = 16;

   // ====================
   // Video settings
   // ====================

   typedef enum logic [ASPECT_W-1:0] {
      ASPECT_ORIGINAL = 2'd0,
      ASPECT_FULL     = 2'd1,
      ASPECT_ARC1     = 2'd2,
      ASPECT_ARC2     = 2'd3
   } aspect_t;

   // Scandoubler effect, values 5..7 are unused
   typedef enum logic [SCALE_W-1:0] {
      SCALE_NONE  = 3'd0,
      SCALE_HQ2X  = 3'd1,
      SCALE_CRT25 = 3'd2,
      SCALE_CRT50 = 3'd3,
      SCALE_CRT75 = 3'd4
   } scale_t;

   typedef logic [RATIO_W-1:0] ratio_t;

   // Native 4:3 ratio of the MSX picture
   localparam int ARX_ORIGINAL = 4;
   localparam int ARY_ORIGINAL = 3;

   // Crop 216 lines on a full HD display
   localparam int CROP_1080   = 216;
   localparam int HDMI_W_FULL = 1920;
   localparam int HDMI_H_FULL = 1080;

   // ====================
   // SD, download, DDR3
   // ====================

   // Shortened hold time of the disk activity LED
   localparam int SD_ACT_CYCLES = 1024;
   localparam int SD_ACT_W      = $clog2(SD_ACT_CYCLES + 1);

   typedef logic [DDR_ADDR_W-1:0] ddr_addr_t;
   typedef logic [DL_INDEX_W-1:0] dl_index_t;

   // CAS files arrive with this index, only the low bits count
   localparam int DL_INDEX_CAS = 5;
   localparam int DL_MATCH_W   = 6;

endpackage

// File: hdl/sd_route.sv
module sd_route (
   input  logic                                  clock_bus,
   input  logic                                  rst,
   input  logic                                  img_mounted,
   input  logic [msx_frame_pkg::IMG_SIZE_W-1:0]  img_size,
   input  logic                                  spi_clk,
   input  logic                                  spi_mosi,
   input  logic                                  vsd_miso,
   input  logic                                  sd_miso,
   output logic                                  spi_miso,
   output logic                                  sd_cs,
   output logic                                  sd_sck,
   output logic                                  sd_mosi,
   output logic                                  vsd_sel,
   output logic                                  sd_act
);

   logic [msx_frame_pkg::SD_ACT_W-1:0] act_cnt;
   logic                               old_mosi;
   logic                               old_miso;
   logic                               line_change;

   // ====================
   // Card or image select
   // ====================

   // A mounted image with a size takes over the SPI bus
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted) begin
         vsd_sel <= |img_size;
      end
   end

   // ====================
   // SPI routing
   // ====================

   // Physical card is deselected while the image is in use
   assign sd_cs   = vsd_sel;
   assign sd_sck  = spi_clk & ~vsd_sel;
   assign sd_mosi = spi_mosi & ~vsd_sel;

   assign spi_miso = vsd_sel ? vsd_miso : sd_miso;

   // ====================
   // Activity timeout
   // ====================

   // Previous line levels for edge detection
   always_ff @(posedge clock_bus) begin
      old_mosi <= spi_mosi;
      old_miso <= spi_miso;
   end

   assign line_change = (old_mosi ^ spi_mosi) | (old_miso ^ spi_miso);

   always_ff @(posedge clock_bus) begin
      if (rst) begin
         // Start expired so the LED stays dark
         act_cnt <= msx_frame_pkg::SD_ACT_W'(msx_frame_pkg::SD_ACT_CYCLES);
         sd_act  <= 1'b0;
      end else begin
         sd_act <= 1'b0;
         if (act_cnt < msx_frame_pkg::SD_ACT_W'(msx_frame_pkg::SD_ACT_CYCLES)) begin
            act_cnt <= act_cnt + 1'b1;
            sd_act  <= 1'b1;
         end
         // Any bus traffic restarts the hold time
         if (line_change) begin
            act_cnt <= '0;
         end
      end
   end

   a_sck_quiet : assert property (
      @(posedge clock_bus) vsd_sel |-> !sd_sck
   ) else $error("sd_sck toggles while the image is selected");

   a_cnt_limit : assert property (
      @(posedge clock_bus) disable iff (rst)
      act_cnt <= msx_frame_pkg::SD_ACT_W'(msx_frame_pkg::SD_ACT_CYCLES)
   ) else $error("activity counter past its limit");

endmodule

// File: hdl/status_decode.sv
module status_decode (
   input  logic                   clock_bus,
   input  logic                   rst,
   input  msx_frame_pkg::status_t status,
   input  logic                   upload_reset,
   input  logic                   forced_scandoubler,
   settings_if.decode_mp          settings,
   output logic                   hard_reset,
   output logic                   core_reset,
   output logic                   sram_save,
   output logic                   sram_load,
   output logic                   tape_adc_src
);

   logic                   hard_next;
   logic                   core_next;
   msx_frame_pkg::aspect_t aspect_field;
   msx_frame_pkg::scale_t  scale_field;

   // ====================
   // Reset terms
   // ====================

   assign hard_next = rst | status[msx_frame_pkg::ST_RESET] | upload_reset;

   // Detaching the cartridge restarts the core only
   assign core_next = hard_next | status[msx_frame_pkg::ST_SLOT_DETACH];

   // Both resets follow rst one cycle later
   always_ff @(posedge clock_bus) begin
      hard_reset <= hard_next;
      core_reset <= core_next;
   end

   // ====================
   // Setting fields
   // ====================

   assign aspect_field = msx_frame_pkg::aspect_t'(
      status[msx_frame_pkg::ST_ASPECT_LO +: msx_frame_pkg::ASPECT_W]);
   assign scale_field  = msx_frame_pkg::scale_t'(
      status[msx_frame_pkg::ST_SCALE_LO +: msx_frame_pkg::SCALE_W]);

   always_ff @(posedge clock_bus) begin
      if (rst) begin
         settings.aspect      <= msx_frame_pkg::ASPECT_ORIGINAL;
         settings.scale       <= msx_frame_pkg::SCALE_NONE;
         settings.scandoubler <= 1'b0;
         // Tape rewinds while the machine is held in reset
         settings.tape_rewind <= 1'b1;
         sram_save            <= 1'b0;
         sram_load            <= 1'b0;
         tape_adc_src         <= 1'b0;
      end else begin
         settings.aspect      <= aspect_field;
         settings.scale       <= scale_field;
         settings.scandoubler <= forced_scandoubler |
                                 (scale_field != msx_frame_pkg::SCALE_NONE);
         settings.tape_rewind <= status[msx_frame_pkg::ST_TAPE_REWIND];
         sram_save            <= status[msx_frame_pkg::ST_SRAM_SAVE];
         sram_load            <= status[msx_frame_pkg::ST_SRAM_LOAD];
         tape_adc_src         <= status[msx_frame_pkg::ST_TAPE_SRC];
      end
   end

   // Core never runs while the whole machine is in reset
   a_core_covers_hard : assert property (
      @(posedge clock_bus) hard_reset |-> core_reset
   ) else $error("core_reset low while hard_reset high");

endmodule

// File: hdl/video_format.sv
module video_format (
   input  logic                                  clock_bus,
   input  logic                                  rst,
   settings_if.result_mp                         settings,
   input  logic [msx_frame_pkg::HDMI_DIM_W-1:0]  hdmi_width,
   input  logic [msx_frame_pkg::HDMI_DIM_W-1:0]  hdmi_height,
   input  logic                                  vsd_sel,
   input  logic                                  sd_act,
   output msx_frame_pkg::ratio_t                 video_arx,
   output msx_frame_pkg::ratio_t                 video_ary,
   output logic [1:0]                            vga_sl,
   output msx_frame_pkg::ratio_t                 crop_size,
   output logic                                  hq2x,
   output logic                                  led_user,
   output logic [1:0]                            led_disk
);

   logic                                is_original;
   logic [msx_frame_pkg::SCALE_W-1:0]   sl_full;
   logic                                full_hd;

   assign is_original = settings.aspect == msx_frame_pkg::ASPECT_ORIGINAL;

   // Scanline level one step below the effect code
   assign sl_full = msx_frame_pkg::SCALE_W'(settings.scale) - 1'b1;

   // Cropping only pays off without the scandoubler
   assign full_hd = (hdmi_width == msx_frame_pkg::HDMI_DIM_W'(msx_frame_pkg::HDMI_W_FULL)) &&
                    (hdmi_height == msx_frame_pkg::HDMI_DIM_W'(msx_frame_pkg::HDMI_H_FULL)) &&
                    !settings.scandoubler;

   // ====================
   // Registered outputs
   // ====================

   always_ff @(posedge clock_bus) begin
      if (rst) begin
         video_arx <= msx_frame_pkg::ratio_t'(msx_frame_pkg::ARX_ORIGINAL);
         video_ary <= msx_frame_pkg::ratio_t'(msx_frame_pkg::ARY_ORIGINAL);
         vga_sl    <= 2'b00;
         crop_size <= '0;
         hq2x      <= 1'b0;
         led_user  <= 1'b0;
         led_disk  <= 2'b00;
      end else begin
         if (is_original) begin
            video_arx <= msx_frame_pkg::ratio_t'(msx_frame_pkg::ARX_ORIGINAL);
            video_ary <= msx_frame_pkg::ratio_t'(msx_frame_pkg::ARY_ORIGINAL);
         end else begin
            // Small values select the scaler's preset ratios
            video_arx <= msx_frame_pkg::ratio_t'(settings.aspect) - 1'b1;
            video_ary <= '0;
         end
         vga_sl    <= (settings.scale != msx_frame_pkg::SCALE_NONE) ? sl_full[1:0] : 2'b00;
         crop_size <= full_hd ? msx_frame_pkg::ratio_t'(msx_frame_pkg::CROP_1080) : '0;
         hq2x      <= settings.scale == msx_frame_pkg::SCALE_HQ2X;
         // Image traffic on the user LED, card traffic on the disk LED
         led_user  <= vsd_sel & sd_act;
         led_disk  <= {1'b1, ~vsd_sel & sd_act};
      end
   end

endmodule

// File: msx_frame.f
hdl/msx_frame_pkg.sv
hdl/frame_if.sv
hdl/status_decode.sv
hdl/sd_route.sv
hdl/cassette_control.sv
hdl/video_format.sv
hdl/msx_frame.sv
tb/tb_clock.sv
tb/tb_msx_frame.sv

// File: tb/tb_clock.sv
module tb_clock (
   output logic clock_bus,
   output logic rst
);

   timeunit 1ns;
   timeprecision 1ps;

   // 40 ns period
   localparam int HALF_PERIOD  = 20;
   localparam int RESET_CYCLES = 8;

   initial begin
      clock_bus = 1'b0;
      forever #HALF_PERIOD clock_bus = ~clock_bus;
   end

   // Release away from the rising edge
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clock_bus);
      @(negedge clock_bus);
      rst = 1'b0;
   end

endmodule

// File: tb/tb_msx_frame.sv
module tb_msx_frame;

   timeunit 1ns;
   timeprecision 1ps;

   typedef struct {
      msx_frame_pkg::status_t status;
      logic                   upload;
      logic [11:0]            width;
      logic [11:0]            height;
      int                     wait_cycles;
      msx_frame_pkg::ratio_t  arx;
      msx_frame_pkg::ratio_t  ary;
      msx_frame_pkg::ratio_t  crop;
      logic [1:0]             sl;
      logic                   hq2x;
      logic                   hard;
      logic                   core;
      logic                   save;
      logic                   load;
      logic                   adc;
   } row_t;

   localparam int SETTLE_NS       = 10;
   localparam int ACT_RISE_CYCLES = 3;
   localparam int DDR_TRIES       = 16;

   logic                             clock_bus;
   logic                             rst;
   msx_frame_pkg::status_t           status;
   logic                             upload_reset;
   logic                             forced_scandoubler;
   logic                             hard_reset;
   logic                             core_reset;
   logic                             sram_save;
   logic                             sram_load;
   logic                             tape_adc_src;
   logic                             img_mounted;
   logic [63:0]                      img_size;
   logic                             spi_clk;
   logic                             spi_mosi;
   logic                             vsd_miso;
   logic                             sd_miso;
   logic                             spi_miso;
   logic                             sd_cs;
   logic                             sd_sck;
   logic                             sd_mosi;
   logic                             dl_active;
   msx_frame_pkg::dl_index_t         dl_index;
   logic                             motor_on;
   logic                             dl_request;
   msx_frame_pkg::ddr_addr_t         dl_addr;
   logic                             dl_rd;
   msx_frame_pkg::ddr_addr_t         tape_addr;
   logic                             tape_rd;
   msx_frame_pkg::ddr_addr_t         ddr_addr;
   logic                             ddr_rd;
   logic                             cas_load;
   logic                             tape_play;
   logic                             tape_rewind_out;
   logic [11:0]                      hdmi_width;
   logic [11:0]                      hdmi_height;
   msx_frame_pkg::ratio_t            video_arx;
   msx_frame_pkg::ratio_t            video_ary;
   logic [1:0]                       vga_sl;
   msx_frame_pkg::ratio_t            crop_size;
   logic                             hq2x;
   logic                             led_user;
   logic [1:0]                       led_disk;

   row_t        table_rows[$];
   logic [31:0] rng_state   = 32'd93;
   int          cycle_count = 0;
   int          cycle_limit = 0;

   tb_clock u_clock (
      .clock_bus (clock_bus),
      .rst       (rst)
   );

   msx_frame dut (.*);

   // ====================
   // Helpers
   // ====================

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Testbench failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check_ratio(input string name, input msx_frame_pkg::ratio_t got,
                              input msx_frame_pkg::ratio_t exp);
      if (got !== exp)
         abort_run($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   task automatic check_bits(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
      if (got !== exp)
         abort_run($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   task automatic check_addr(input string name, input msx_frame_pkg::ddr_addr_t got,
                             input msx_frame_pkg::ddr_addr_t exp);
      if (got !== exp)
         abort_run($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   // Row with neutral video settings on a 720p display
   function automatic row_t reset_row(input int bit_pos, input logic upload,
                                      input logic hard, input logic core);
      row_t r;
      r = '{status: '0, upload: upload, width: 12'd1280, height: 12'd720,
            wait_cycles: 2, arx: 12'd4, ary: 12'd3, crop: '0, sl: 2'd0,
            hq2x: 1'b0, hard: hard, core: core,
            save: 1'b0, load: 1'b0, adc: 1'b0};
      if (bit_pos >= 0)
         r.status[bit_pos] = 1'b1;
      return r;
   endfunction

   task automatic build_table();
      row_t r;
      for (int a = 0; a < 4; a++) begin
         for (int s = 0; s < 5; s++) begin
            for (int h = 0; h < 2; h++) begin
               r = reset_row(-1, 1'b0, 1'b0, 1'b0);
               r.status[msx_frame_pkg::ST_ASPECT_LO +: 2] = 2'(a);
               r.status[msx_frame_pkg::ST_SCALE_LO +: 3]  = 3'(s);
               r.width  = (h == 0) ? 12'(msx_frame_pkg::HDMI_W_FULL) : 12'd1280;
               r.height = (h == 0) ? 12'(msx_frame_pkg::HDMI_H_FULL) : 12'd720;
               r.arx    = (a == 0) ? 12'd4 : 12'(a - 1);
               r.ary    = (a == 0) ? 12'd3 : 12'd0;
               r.sl     = (s == 0) ? 2'd0 : 2'(s - 1);
               r.hq2x   = (s == 1);
               // Any effect turns the scandoubler on, which stops the crop
               r.crop   = (h == 0 && s == 0) ? 12'(msx_frame_pkg::CROP_1080) : 12'd0;
               table_rows.push_back(r);
            end
         end
      end
      table_rows.push_back(reset_row(msx_frame_pkg::ST_RESET, 1'b0, 1'b1, 1'b1));
      table_rows.push_back(reset_row(-1, 1'b1, 1'b1, 1'b1));
      table_rows.push_back(reset_row(msx_frame_pkg::ST_SLOT_DETACH, 1'b0, 1'b0, 1'b1));
      // Backup and tape source flags, one at a time
      r = reset_row(msx_frame_pkg::ST_SRAM_SAVE, 1'b0, 1'b0, 1'b0);
      r.save = 1'b1;
      table_rows.push_back(r);
      r = reset_row(msx_frame_pkg::ST_SRAM_LOAD, 1'b0, 1'b0, 1'b0);
      r.load = 1'b1;
      table_rows.push_back(r);
      r = reset_row(msx_frame_pkg::ST_TAPE_SRC, 1'b0, 1'b0, 1'b0);
      r.adc = 1'b1;
      table_rows.push_back(r);
      table_rows.push_back(reset_row(-1, 1'b0, 1'b0, 1'b0));
   endtask

   task automatic apply_table();
      foreach (table_rows[i]) begin
         status       = table_rows[i].status;
         upload_reset = table_rows[i].upload;
         hdmi_width   = table_rows[i].width;
         hdmi_height  = table_rows[i].height;
         repeat (table_rows[i].wait_cycles) @(posedge clock_bus);
         @(negedge clock_bus);
         check_ratio("video_arx", video_arx, table_rows[i].arx);
         check_ratio("video_ary", video_ary, table_rows[i].ary);
         check_ratio("crop_size", crop_size, table_rows[i].crop);
         check_bits("vga_sl", vga_sl, table_rows[i].sl);
         check_bits("hq2x", hq2x, table_rows[i].hq2x);
         check_bits("hard_reset", hard_reset, table_rows[i].hard);
         check_bits("core_reset", core_reset, table_rows[i].core);
         check_bits("sram_save", sram_save, table_rows[i].save);
         check_bits("sram_load", sram_load, table_rows[i].load);
         check_bits("tape_adc_src", tape_adc_src, table_rows[i].adc);
      end
   endtask

   // ====================
   // SD card and image
   // ====================

   task automatic mount_image(input logic [63:0] size);
      @(negedge clock_bus);
      img_mounted = 1'b1;
      img_size    = size;
      @(negedge clock_bus);
      img_mounted = 1'b0;
      #SETTLE_NS;
      check_bits("sd_cs", sd_cs, size != 0);
   endtask

   task automatic route_sd_lines();
      mount_image(64'h0000_0000_0010_0000);
      @(negedge clock_bus);
      spi_clk  = 1'b1;
      spi_mosi = 1'b1;
      vsd_miso = 1'b1;
      sd_miso  = 1'b0;
      #SETTLE_NS;
      check_bits("sd_sck", sd_sck, 1'b0);
      check_bits("sd_mosi", sd_mosi, 1'b0);
      check_bits("spi_miso", spi_miso, vsd_miso);
      mount_image(64'h0);
      @(negedge clock_bus);
      vsd_miso = 1'b0;
      sd_miso  = 1'b1;
      #SETTLE_NS;
      check_bits("sd_sck", sd_sck, spi_clk);
      check_bits("sd_mosi", sd_mosi, spi_mosi);
      check_bits("spi_miso", spi_miso, sd_miso);
      @(negedge clock_bus);
      spi_clk  = 1'b0;
      spi_mosi = 1'b0;
      sd_miso  = 1'b0;
   endtask

   task automatic watch_activity(input logic image);
      int waited;
      mount_image(image ? 64'h200 : 64'h0);
      // Earlier traffic has to time out before the new toggle
      waited = 0;
      while (led_user !== 1'b0 || led_disk !== 2'b10) begin
         if (waited > msx_frame_pkg::SD_ACT_CYCLES + ACT_RISE_CYCLES)
            abort_run("activity LED stayed lit with the SPI lines idle");
         @(negedge clock_bus);
         waited++;
      end
      @(negedge clock_bus);
      spi_mosi = ~spi_mosi;
      waited   = 0;
      while ((image ? led_user : led_disk[0]) !== 1'b1) begin
         if (waited == ACT_RISE_CYCLES)
            abort_run("activity LED did not light after SPI traffic");
         @(negedge clock_bus);
         waited++;
      end
      check_bits("led_user", led_user, image);
      check_bits("led_disk", led_disk, {1'b1, ~image});
      // Lines held still from here on
      repeat (msx_frame_pkg::SD_ACT_CYCLES + 3 - waited) @(negedge clock_bus);
      check_bits("led_user", led_user, 1'b0);
      check_bits("led_disk", led_disk, 2'b10);
   endtask

   // ====================
   // Cassette and DDR3
   // ====================

   task automatic run_download(input msx_frame_pkg::dl_index_t index, input logic rewind);
      @(negedge clock_bus);
      dl_index  = index;
      dl_active = 1'b1;
      repeat (3) @(negedge clock_bus);
      check_bits("tape_rewind_out", tape_rewind_out, rewind);
      dl_active = 1'b0;
      repeat (2) @(posedge clock_bus);
      @(negedge clock_bus);
   endtask

   task automatic cassette_sequence();
      msx_frame_pkg::dl_index_t other;
      rng_state = xorshift(rng_state);
      other     = rng_state[15:0];
      if (other[5:0] == 6'(msx_frame_pkg::DL_INDEX_CAS))
         other[0] = ~other[0];
      run_download(other, 1'b0);
      check_bits("cas_load", cas_load, 1'b0);
      run_download(16'(msx_frame_pkg::DL_INDEX_CAS), 1'b1);
      check_bits("cas_load", cas_load, 1'b1);
      motor_on = 1'b0;
      #SETTLE_NS;
      check_bits("tape_play", tape_play, 1'b1);
      @(negedge clock_bus);
      motor_on = 1'b1;
      #SETTLE_NS;
      check_bits("tape_play", tape_play, 1'b0);
   endtask

   task automatic ddr_arbitration();
      for (int i = 0; i < DDR_TRIES; i++) begin
         @(negedge clock_bus);
         rng_state  = xorshift(rng_state);
         dl_addr    = rng_state[27:0];
         rng_state  = xorshift(rng_state);
         tape_addr  = rng_state[27:0];
         rng_state  = xorshift(rng_state);
         dl_request = rng_state[0];
         dl_rd      = rng_state[1];
         tape_rd    = rng_state[2];
         #SETTLE_NS;
         check_addr("ddr_addr", ddr_addr, dl_request ? dl_addr : tape_addr);
         check_bits("ddr_rd", ddr_rd, dl_request ? dl_rd : tape_rd);
      end
   endtask

   // ====================
   // Run
   // ====================

   always @(posedge clock_bus) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit)
         abort_run($sformatf("timeout after %0d cycles", cycle_count));
   end

   initial begin
      int wait_sum;
      status             = '0;
      upload_reset       = 1'b0;
      forced_scandoubler = 1'b0;
      img_mounted        = 1'b0;
      img_size           = '0;
      spi_clk            = 1'b0;
      spi_mosi           = 1'b0;
      vsd_miso           = 1'b0;
      sd_miso            = 1'b0;
      dl_active          = 1'b0;
      dl_index           = '0;
      motor_on           = 1'b0;
      dl_request         = 1'b0;
      dl_addr            = '0;
      dl_rd              = 1'b0;
      tape_addr          = '0;
      tape_rd            = 1'b0;
      hdmi_width         = 12'd1280;
      hdmi_height        = 12'd720;
      build_table();
      wait_sum = 0;
      foreach (table_rows[i])
         wait_sum += table_rows[i].wait_cycles;
      cycle_limit = 2 * wait_sum + 4 * msx_frame_pkg::SD_ACT_CYCLES;

      // Outputs still show the reset state right after release
      @(negedge rst);
      check_bits("hard_reset", hard_reset, 1'b1);
      check_bits("core_reset", core_reset, 1'b1);
      check_bits("tape_rewind_out", tape_rewind_out, 1'b1);
      check_bits("cas_load", cas_load, 1'b0);
      check_bits("led_disk", led_disk, 2'b00);
      check_ratio("video_arx", video_arx, 12'd4);
      check_ratio("video_ary", video_ary, 12'd3);

      apply_table();
      route_sd_lines();
      watch_activity(1'b0);
      watch_activity(1'b1);
      cassette_sequence();
      ddr_arbitration();

      $display("Testbench passed");
      $finish;
   end

endmodule
